// File: hw/emesh_pkg.sv
`default_nettype none

package emesh_pkg;

   //##########################################################################
   // Packet and address geometry
   //##########################################################################
   localparam int AW    = 32;                     // Address width
   localparam int DW    = 32;                     // Data width
   localparam int ID_W  = 12;                     // Chip ID in dst_addr[31:20]

   localparam logic [ID_W-1:0] ELINK_ID = 12'h810; // Own link ID, dropped at memory
   localparam logic [ID_W-1:0] CHIP_ID  = 12'h808; // Memory endpoint ID

   //##########################################################################
   // Memory and burst sizing
   //##########################################################################
   localparam int MEM_WORDS = 16;                 // Word array depth
   localparam int MEM_AW    = $clog2(MEM_WORDS);  // Index taken from addr[5:2]

   localparam int BURST_LEN = 16;                 // Writes and reads per run
   localparam int CNT_W     = $clog2(BURST_LEN);  // Burst counter width
   localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(BURST_LEN - 1); // Final beat

   // Write data is the word address XOR this key
   localparam logic [DW-1:0] DATA_KEY = 32'h5A3C_96E1;

   //##########################################################################
   // Enumerations
   //##########################################################################
   typedef enum logic [1:0] {
      OP_WRITE = 2'd0,                            // Store word
      OP_READ  = 2'd1,                            // Fetch word, reply to src_addr
      OP_RESP  = 2'd2                             // Read response
   } emesh_op_t;

   typedef enum logic [2:0] {
      GEN_IDLE  = 3'd0,                           // Wait for start
      GEN_WRITE = 3'd1,                           // Write burst to CHIP_ID
      GEN_SELF  = 3'd2,                           // One write to ELINK_ID
      GEN_READ  = 3'd3,                           // Read burst back
      GEN_DONE  = 3'd4                            // One cycle done pulse
   } gen_state_t;

endpackage

`default_nettype wire

// File: hw/emesh_if.sv
`default_nettype none

// One eMesh packet with access/wait flow control
interface emesh_if;
   logic                      access;              // Packet valid
   emesh_pkg::emesh_op_t      op;                  // Write, read or response
   logic [emesh_pkg::AW-1:0]  dst_addr;            // Target ID and word address
   logic [emesh_pkg::DW-1:0]  data;                // Write data
   logic [emesh_pkg::AW-1:0]  src_addr;            // Return address for reads
   logic                      pkt_wait;            // Push back from receiver

   modport src (
      output access, op, dst_addr, data, src_addr,
      input  pkt_wait
   );

   modport dst (
      input  access, op, dst_addr, data, src_addr,
      output pkt_wait
   );
endinterface

`default_nettype wire

// File: hw/emesh_gen.sv
`default_nettype none

module emesh_gen (
   input  logic  sys_clk,
   input  logic  reset,
   input  logic  start,                            // Kick off one run
   output logic  done,                             // Last read accepted
   emesh_if.src  tx
);

   emesh_pkg::gen_state_t          state;          // Run sequencer
   logic [emesh_pkg::CNT_W-1:0]    idx;            // Beat within burst
   logic                           xfer;           // Packet taken this cycle
   logic                           last;           // Final beat of burst

   // Build {id, zeros, idx, 2'b00}
   function automatic logic [emesh_pkg::AW-1:0] word_addr(
      input logic [emesh_pkg::ID_W-1:0]  id,
      input logic [emesh_pkg::CNT_W-1:0] i
   );
      word_addr = {id, {(emesh_pkg::AW - emesh_pkg::ID_W - emesh_pkg::CNT_W - 2){1'b0}},
                   i, 2'b00};
   endfunction

   assign xfer = tx.access & ~tx.pkt_wait;         // Fields move only on this
   assign last = (idx == emesh_pkg::LAST_IDX);
   assign done = (state == emesh_pkg::GEN_DONE);   // Decoded, one cycle wide

   //##########################################################################
   // Packet fields, decoded from state and beat
   //##########################################################################
   always_comb begin
      tx.access   = 1'b0;
      tx.op       = emesh_pkg::OP_WRITE;
      tx.dst_addr = word_addr(emesh_pkg::CHIP_ID, idx);
      tx.data     = word_addr(emesh_pkg::CHIP_ID, idx) ^ emesh_pkg::DATA_KEY;
      tx.src_addr = word_addr(emesh_pkg::ELINK_ID, idx); // Reply slot per beat
      case (state)
         emesh_pkg::GEN_WRITE: begin
            tx.access = 1'b1;                      // Key-derived data
         end
         emesh_pkg::GEN_SELF: begin
            tx.access   = 1'b1;
            tx.dst_addr = word_addr(emesh_pkg::ELINK_ID, '0); // Must be filtered
            tx.data     = ~(word_addr(emesh_pkg::CHIP_ID, '0) ^ emesh_pkg::DATA_KEY);
         end
         emesh_pkg::GEN_READ: begin
            tx.access = 1'b1;
            tx.op     = emesh_pkg::OP_READ;
            tx.data   = '0;                        // No payload on reads
         end
         default: begin
         end
      endcase
   end

   //##########################################################################
   // Sequencer
   //##########################################################################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         state <= emesh_pkg::GEN_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            emesh_pkg::GEN_IDLE: begin
               idx <= '0;
               if (start) state <= emesh_pkg::GEN_WRITE;
            end
            emesh_pkg::GEN_WRITE: begin
               if (xfer) begin
                  idx <= last ? '0 : idx + 1'b1;
                  if (last) state <= emesh_pkg::GEN_SELF;
               end
            end
            emesh_pkg::GEN_SELF: begin
               if (xfer) state <= emesh_pkg::GEN_READ; // idx already back at 0
            end
            emesh_pkg::GEN_READ: begin
               if (xfer) begin
                  idx <= last ? '0 : idx + 1'b1;
                  if (last) state <= emesh_pkg::GEN_DONE;
               end
            end
            default: state <= emesh_pkg::GEN_IDLE; // GEN_DONE lasts one cycle
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/link_channel.sv
`default_nettype none

module link_channel (
   input  logic  sys_clk,
   input  logic  reset,
   emesh_if.dst  rx,                               // From generator
   emesh_if.src  tx                                // Toward memory
);

   // Stage 0 captures from rx, stage 1 drives tx
   logic                      s0_valid, s1_valid;
   emesh_pkg::emesh_op_t      s0_op, s1_op;
   logic [emesh_pkg::AW-1:0]  s0_dst, s1_dst;
   logic [emesh_pkg::DW-1:0]  s0_data, s1_data;
   logic [emesh_pkg::AW-1:0]  s0_src, s1_src;
   logic                      s1_adv;              // Stage 1 may load
   logic                      s0_adv;              // Stage 0 may load

   assign s1_adv = ~s1_valid | ~tx.pkt_wait;       // Empty or draining
   assign s0_adv = ~s0_valid | s1_adv;
   assign rx.pkt_wait = ~s0_adv;                   // Both full and output stalled

   assign tx.access   = s1_valid;
   assign tx.op       = s1_op;
   assign tx.dst_addr = s1_dst;
   assign tx.data     = s1_data;
   assign tx.src_addr = s1_src;

   // Valid bits, cleared by reset
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         s0_valid <= 1'b0;
         s1_valid <= 1'b0;
      end else begin
         if (s0_adv) s0_valid <= rx.access;        // Wait is low here
         if (s1_adv) s1_valid <= s0_valid;
      end
   end

   // Payload follows its valid bit
   always_ff @(posedge sys_clk) begin
      if (s0_adv) begin
         s0_op   <= rx.op;
         s0_dst  <= rx.dst_addr;
         s0_data <= rx.data;
         s0_src  <= rx.src_addr;
      end
      if (s1_adv) begin
         s1_op   <= s0_op;
         s1_dst  <= s0_dst;
         s1_data <= s0_data;
         s1_src  <= s0_src;
      end
   end

endmodule

`default_nettype wire

// File: hw/emesh_memory.sv
`default_nettype none

module emesh_memory (
   input  logic                     sys_clk,
   input  logic                     reset,
   emesh_if.dst                     rx,            // Packets from link
   output logic                     rr_access,     // Read response valid
   output logic [emesh_pkg::AW-1:0] rr_dst_addr,   // Requester's src_addr
   output logic [emesh_pkg::DW-1:0] rr_data,       // Stored word
   input  logic                     rr_wait        // Push back on responses
);

   logic [emesh_pkg::DW-1:0]      mem [emesh_pkg::MEM_WORDS]; // Word array
   logic [emesh_pkg::MEM_AW-1:0]  widx;            // Word index from addr[5:2]
   logic                          hit;             // Addressed to this chip
   logic                          rr_stall;        // Response held by rr_wait
   logic                          xfer;            // Packet taken this cycle
   logic                          do_write;
   logic                          do_read;

   //##########################################################################
   // Destination filter
   //##########################################################################
   assign hit  = (rx.dst_addr[emesh_pkg::AW-1 -: emesh_pkg::ID_W] == emesh_pkg::CHIP_ID);
   assign widx = rx.dst_addr[emesh_pkg::MEM_AW+1:2];

   // Other IDs, ELINK_ID included, go straight through and vanish
   assign rr_stall    = rr_access & rr_wait;
   assign rx.pkt_wait = rr_stall & hit;            // Only real traffic waits
   assign xfer        = rx.access & ~rx.pkt_wait;

   always_comb begin
      do_write = 1'b0;
      do_read  = 1'b0;
      if (xfer && hit) begin
         case (rx.op)
            emesh_pkg::OP_WRITE: do_write = 1'b1;
            emesh_pkg::OP_READ:  do_read  = 1'b1;
            emesh_pkg::OP_RESP: begin
               // Responses are not served here
            end
            default: begin
            end
         endcase
      end
   end

   //##########################################################################
   // Storage
   //##########################################################################
   always_ff @(posedge sys_clk) begin
      if (do_write) mem[widx] <= rx.data;          // Stored in transfer cycle
   end

   //##########################################################################
   // Read response register
   //##########################################################################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         rr_access <= 1'b0;
      end else if (!rr_stall) begin
         rr_access <= do_read;                     // Valid the cycle after read
      end
   end

   always_ff @(posedge sys_clk) begin
      if (do_read) begin                           // Never true while stalled
         rr_dst_addr <= rx.src_addr;               // OP_RESP back to requester
         rr_data     <= mem[widx];
      end
   end

endmodule

`default_nettype wire

// File: hw/elink_loop.sv
`default_nettype none

module elink_loop (
   input  logic                     sys_clk,
   input  logic                     reset,         // Synchronous, active high
   input  logic                     start,         // Launch one run
   output logic                     done,          // Last read in the channel
   output logic                     rr_access,     // Read responses
   output logic [emesh_pkg::AW-1:0] rr_dst_addr,
   output logic [emesh_pkg::DW-1:0] rr_data,
   input  logic                     rr_wait
);

   emesh_if gen_link ();                           // Generator to channel
   emesh_if link_mem ();                           // Channel to memory

   //##########################################################################
   // Transaction generator, link channel, memory endpoint
   //##########################################################################
   emesh_gen egen (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .start       (start),
      .done        (done),
      .tx          (gen_link.src)
   );

   link_channel elink (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .rx          (gen_link.dst),
      .tx          (link_mem.src)
   );

   emesh_memory emem (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .rx          (link_mem.dst),
      .rr_access   (rr_access),
      .rr_dst_addr (rr_dst_addr),
      .rr_data     (rr_data),
      .rr_wait     (rr_wait)
   );

endmodule

`default_nettype wire

// File: testbench/elink_loop_sva.sv
`default_nettype none

module elink_loop_sva (
   input logic                     sys_clk,
   input logic                     reset,
   input logic                     start,
   input logic                     done,
   input logic                     rr_access,
   input logic [emesh_pkg::AW-1:0] rr_dst_addr,
   input logic [emesh_pkg::DW-1:0] rr_data,
   input logic                     rr_wait
);

   logic started;                                  // Start seen since reset
   int   reset_fails;                              // Failure tallies, read by the testbench
   int   idle_fails;
   int   hold_fails;
   int   pulse_fails;

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         started <= 1'b0;
      end else if (start) begin
         started <= 1'b1;
      end
   end

   //##########################################################################
   // Protocol properties on the top-level ports
   //##########################################################################
   reset_quiet: assert property (@(posedge sys_clk) reset |=> (!rr_access && !done))
      else begin
         reset_fails++;
         $error("rr_access or done high right after reset");
      end

   idle_quiet: assert property (@(posedge sys_clk) disable iff (reset)
      !started |-> (!rr_access && !done))
      else begin
         idle_fails++;
         $error("rr_access or done high before start");
      end

   // Response frozen while the receiver pushes back
   resp_hold: assert property (@(posedge sys_clk) disable iff (reset)
      (rr_access && rr_wait) |=> (rr_access && $stable(rr_dst_addr) && $stable(rr_data)))
      else begin
         hold_fails++;
         $error("read response changed while rr_wait was high");
      end

   done_pulse: assert property (@(posedge sys_clk) disable iff (reset) done |=> !done)
      else begin
         pulse_fails++;
         $error("done held high for more than one cycle");
      end

endmodule

bind elink_loop elink_loop_sva protocol_chk (
   .sys_clk     (sys_clk),
   .reset       (reset),
   .start       (start),
   .done        (done),
   .rr_access   (rr_access),
   .rr_dst_addr (rr_dst_addr),
   .rr_data     (rr_data),
   .rr_wait     (rr_wait)
);

`default_nettype wire

// File: testbench/tb_elink_loop.sv
`default_nettype none

module tb_elink_loop;

   localparam int CLK_HALF   = 20;                 // 40 unit period
   localparam int RESET_CYC  = 16;                 // Cycles held in reset
   localparam int IDLE_CYC   = 8;                  // Quiet window before start
   localparam int DONE_LIMIT = 400;                // Cycles allowed for done
   localparam int RESP_LIMIT = 400;                // Cycles allowed for all responses

   logic                     sys_clk;
   logic                     reset;
   logic                     start;
   logic                     done;
   logic                     rr_access;
   logic [emesh_pkg::AW-1:0] rr_dst_addr;
   logic [emesh_pkg::DW-1:0] rr_data;
   logic                     rr_wait;

   int          resp_errors;                       // Bad or extra responses
   int          seq_errors;                        // Idle and done count checks
   int          timeout_errors;
   int          sva_errors;
   int          resp_count;                        // Responses taken so far
   int          done_count;                        // done pulses seen
   logic [31:0] rand_word;

   elink_loop DUT (
      .sys_clk     (sys_clk),
      .reset       (reset),
      .start       (start),
      .done        (done),
      .rr_access   (rr_access),
      .rr_dst_addr (rr_dst_addr),
      .rr_data     (rr_data),
      .rr_wait     (rr_wait)
   );

   initial sys_clk = 1'b0;
   always #CLK_HALF sys_clk = ~sys_clk;

   // Reply slot k under the link's own ID
   function automatic logic [emesh_pkg::AW-1:0] reply_addr(input int k);
      reply_addr = {emesh_pkg::ELINK_ID, 20'h0} | emesh_pkg::AW'(4 * k);
   endfunction

   // Word the burst wrote at CHIP_ID offset 4k
   function automatic logic [emesh_pkg::DW-1:0] written_word(input int k);
      written_word = ({emesh_pkg::CHIP_ID, 20'h0} | emesh_pkg::DW'(4 * k)) ^ emesh_pkg::DATA_KEY;
   endfunction

   task automatic check_response(input int k);
      logic [emesh_pkg::AW-1:0] exp_addr;
      logic [emesh_pkg::DW-1:0] exp_data;
      exp_addr = reply_addr(k);
      exp_data = written_word(k);
      assert (k < emesh_pkg::BURST_LEN) else begin
         resp_errors++;
         $display("Response %0d arrived after the full read burst", k);
      end
      assert (rr_dst_addr == exp_addr) else begin
         resp_errors++;
         $display("** Error rr_dst_addr resp %0d: got %h expected %h", k, rr_dst_addr, exp_addr);
      end
      assert (rr_data == exp_data) else begin
         resp_errors++;
         $display("** Error rr_data resp %0d: got %h expected %h", k, rr_data, exp_data);
      end
   endtask

   //##########################################################################
   // Receiver side, random rr_wait and response checks on the falling edge
   //##########################################################################
   initial begin
      rand_word   = $urandom(21);                  // Seed once
      rr_wait     = 1'b0;
      resp_count  = 0;
      done_count  = 0;
      resp_errors = 0;
      forever begin
         @(negedge sys_clk);
         rand_word = $urandom;
         rr_wait   = rand_word[0];                 // Stall about half the time
         if (done) done_count++;
         if (rr_access && !rr_wait) begin          // Transfers at next rising edge
            check_response(resp_count);
            resp_count++;
         end
      end
   end

   //##########################################################################
   // Reset, start and the closing report
   //##########################################################################
   initial begin
      int cycles;
      reset          = 1'b1;
      start          = 1'b0;
      seq_errors     = 0;
      timeout_errors = 0;
      repeat (RESET_CYC) @(negedge sys_clk);
      reset = 1'b0;
      repeat (IDLE_CYC) begin                      // Nothing may move before start
         @(negedge sys_clk);
         assert (rr_access == 1'b0) else begin
            seq_errors++;
            $display("** Error rr_access before start: got %h expected %h", rr_access, 1'b0);
         end
         assert (done == 1'b0) else begin
            seq_errors++;
            $display("** Error done before start: got %h expected %h", done, 1'b0);
         end
      end
      start = 1'b1;
      @(negedge sys_clk);
      start = 1'b0;
      cycles = 0;
      while (done_count == 0 && cycles < DONE_LIMIT) begin
         @(posedge sys_clk);
         cycles++;
      end
      if (done_count == 0) begin
         timeout_errors++;
         $display("Timeout waiting for done after start");
      end
      cycles = 0;
      while (resp_count < emesh_pkg::BURST_LEN && cycles < RESP_LIMIT) begin
         @(posedge sys_clk);
         cycles++;
      end
      if (resp_count < emesh_pkg::BURST_LEN) begin
         timeout_errors++;
         $display("Timeout with only %0d read responses received", resp_count);
      end
      repeat (20) @(posedge sys_clk);              // Tail for stray responses or done
      assert (done_count == 1) else begin
         seq_errors++;
         $display("** Error done pulses: got %h expected %h", done_count, 1);
      end
      sva_errors = DUT.protocol_chk.reset_fails + DUT.protocol_chk.idle_fails
                 + DUT.protocol_chk.hold_fails + DUT.protocol_chk.pulse_fails;
      $display("Errors: response %0d, sequence %0d, timeout %0d, assertion %0d",
               resp_errors, seq_errors, timeout_errors, sva_errors);
      if (resp_errors + seq_errors + timeout_errors + sva_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
hw/emesh_pkg.sv
hw/emesh_if.sv
hw/emesh_gen.sv
hw/link_channel.sv
hw/emesh_memory.sv
hw/elink_loop.sv
testbench/elink_loop_sva.sv
testbench/tb_elink_loop.sv

// File: run.sh
#!/bin/sh
# Build and run the elink_loop testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_elink_loop -o sim_elink_loop
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Let assertion failures be counted instead of stopping the run at the first
./obj_dir/sim_elink_loop +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^all tests passed$" sim.log; then
   exit 0
fi
exit 1
